// ==== project.f ====
+incdir+.
motor_pkg.sv
motor_cmd_in.sv
motor_pwm_gen.sv
motor_bridge_drv.sv
motor_ctrl_top.sv
motor_checker.sv
tb_motor.sv

// ==== run.sh ====
#!/bin/sh
# build and run the motor controller testbench with Verilator
cd "$(dirname "$0")" &&
  verilator --binary --assert -f project.f --top-module tb_motor &&
  ./obj_dir/Vtb_motor | tee /dev/stderr | grep -qx "PASS: all tests" &&
  echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// ==== tb_motor.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "motor_cfg.svh"

module tb_motor import motor_pkg::*; ();

  localparam int pre_len   = 4;                  // prescale of the DUT
  localparam int dead_len  = 3;                  // dead time of the DUT
  localparam int per_len   = 8 * pre_len;        // cycles per pwm period
  localparam int n_set     = 12;                 // random OP_SET commands
  localparam int n_mix     = 16;                 // mixed commands, 5 fixed then random
  localparam int cyc_limit = (n_set + n_mix + 4) * 3 * per_len;

  logic                    rst;                  // clock
  logic                    clk;                  // reset
  logic                    cmd_valid;
  logic                    cmd_ready;
  motor_op_e               cmd_op;
  logic                    cmd_dir;
  logic [`MOTOR_VEL_W-1:0] cmd_vel;
  logic                    leg_a_hi;
  logic                    leg_b_hi;
  logic                    pwm_out;
  logic                    pwm_sync;

  logic [31:0]             lfsr = 32'hcc53_08c6;
  int n_err = 0, n_sent = 0, n_acc = 0, n_periods = 0, cycles = 0;
  int tests_run = 0, tests_failed = 0;
  logic mon_on = 1'b0;

  // model state: pending slot, active setting, period bookkeeping
  logic                    m_pend_valid = 1'b0, m_pend_dir = 1'b0, m_pend_brake = 1'b0;
  logic [`MOTOR_VEL_W-1:0] m_pend_vel = '0, m_vel = '0, acc_vel = '0;
  logic                    m_dir = 1'b0, m_brake = 1'b0, m_last_dir = 1'b0;
  logic                    acc_next = 1'b0, acc_dir = 1'b0, acc_brake = 1'b0;
  logic                    started = 1'b0, excl = 1'b0, have_window = 1'b0;
  logic [1:0]              last_side = 2'b00;
  int high_cnt = 0, exp_cnt = 0, cyc_in_per = 0, low_run = 0;

  motor_ctrl_top #(.prescale(pre_len), .dead(dead_len)) DUT (
    .rst(rst), .clk(clk), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
    .cmd_op(cmd_op), .cmd_dir(cmd_dir), .cmd_vel(cmd_vel), .leg_a_hi(leg_a_hi),
    .leg_b_hi(leg_b_hi), .pwm_out(pwm_out), .pwm_sync(pwm_sync)
  );

  initial begin
    rst = 1'b0;
    forever #4 rst = ~rst;  // 8 ns period
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // galois, x^32+x^22+x^2+x+1
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      val  = {val[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  // 0 forward, 1 reverse, 2 brake
  function automatic logic [1:0] leg_target(input logic dir, input logic brake);
    return brake ? 2'd2 : (dir ? 2'd1 : 2'd0);
  endfunction

  // called 1 ns after a rising edge, returns 1 ns after the edge following the transfer
  task automatic send_cmd(input motor_op_e op, input logic dir, input logic [2:0] vel);
    cmd_valid = 1'b1;
    cmd_op    = op;
    cmd_dir   = dir;
    cmd_vel   = vel;
    @(negedge rst);
    while (!cmd_ready) @(negedge rst);  // fields held while not taken
    @(posedge rst);                     // transfer edge
    @(posedge rst);                     // still valid, slot full, no second take
    #1;
    cmd_valid = 1'b0;
    n_sent++;
  endtask

  task automatic rand_cmd(input logic set_only);
    logic [31:0] r_op, r_dir, r_vel, r_gap;
    motor_op_e   op;
    take_bits(2, r_op);
    take_bits(1, r_dir);
    take_bits(3, r_vel);
    take_bits(5, r_gap);
    op = OP_SET;
    if (!set_only && r_op[1:0] == 2'd1) op = OP_STOP;
    if (!set_only && r_op[1:0] == 2'd2) op = OP_BRAKE;
    repeat (r_gap[4:0]) begin
      @(posedge rst);  // idle gap of 0..31 cycles
      #1;
    end
    send_cmd(op, r_dir[0], r_vel[2:0]);
  endtask

  task automatic wait_syncs(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge rst);
      while (!pwm_sync) @(negedge rst);
    end
    @(posedge rst);
    #1;
  endtask

  task automatic end_test(input string name, input int err_before);
    tests_run++;
    if (n_err != err_before) begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, n_err - err_before);
    end else begin
      $display("test %s: passed", name);
    end
  endtask

  // reference model and output checks, sampled mid-cycle
  always @(negedge rst) begin
    logic [1:0] old_tgt, tgt, side;
    logic       exp_a, exp_b;
    if (mon_on) begin
      if (pwm_sync) begin
        if (have_window && cyc_in_per != per_len) begin
          n_err++;
          $display("ERROR %0t: pwm_sync after %0d cycles, expected %0d",
                   $time, cyc_in_per, per_len);
        end
        if (have_window && !excl) begin
          n_periods++;
          if (high_cnt != exp_cnt) begin
            n_err++;
            $display("ERROR %0t: pwm_out high %0d cycles in period, expected %0d",
                     $time, high_cnt, exp_cnt);
          end
        end
        old_tgt = leg_target(m_dir, m_brake);
        if (m_pend_valid) begin  // period end takes the slot
          m_vel        = m_pend_vel;
          m_dir        = m_pend_dir;
          m_brake      = m_pend_brake;
          m_pend_valid = 1'b0;
        end
        excl = started && (leg_target(m_dir, m_brake) != old_tgt);  // dead phase inside
        if (m_vel != '0 || m_brake) started = 1'b1;
        exp_cnt     = int'(m_vel) * pre_len;
        high_cnt    = 0;
        cyc_in_per  = 0;
        have_window = 1'b1;
      end
      if (acc_next) begin  // transfer on the edge before this cycle
        m_pend_valid = 1'b1;
        m_pend_vel   = acc_vel;
        m_pend_dir   = acc_dir;
        m_pend_brake = acc_brake;
        m_last_dir   = acc_dir;
        acc_next     = 1'b0;
        n_acc++;
      end
      if (cmd_ready == m_pend_valid) begin
        n_err++;
        $display("ERROR %0t: cmd_ready is %b with model slot full %b",
                 $time, cmd_ready, m_pend_valid);
      end
      if (cmd_valid && cmd_ready) begin
        acc_next  = 1'b1;
        acc_vel   = (cmd_op == OP_SET) ? cmd_vel : '0;
        acc_dir   = (cmd_op == OP_SET) ? cmd_dir : m_last_dir;  // stop, brake keep it
        acc_brake = (cmd_op == OP_BRAKE);
      end
      if (pwm_out) high_cnt++;
      tgt   = leg_target(m_dir, m_brake);
      exp_a = started && (tgt != 2'd1);
      exp_b = started && (tgt != 2'd0);
      if ((!started || cyc_in_per > dead_len) && (leg_a_hi != exp_a || leg_b_hi != exp_b)) begin
        n_err++;
        $display("ERROR %0t: legs a=%b b=%b, expected a=%b b=%b",
                 $time, leg_a_hi, leg_b_hi, exp_a, exp_b);
      end
      side = {leg_b_hi, leg_a_hi};
      if (side != 2'b00) begin
        if (last_side != 2'b00 && side != last_side && low_run < dead_len) begin
          n_err++;
          $display("ERROR %0t: leg change after only %0d low cycles", $time, low_run);
        end
        last_side = side;
        low_run   = 0;
      end else begin
        low_run++;
      end
      cyc_in_per++;
    end
  end

  initial begin
    while (cycles < cyc_limit) begin
      @(posedge rst);
      cycles++;
    end
    $display("timeout: run did not finish within %0d clock cycles", cyc_limit);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    int e0;
    cmd_valid = 1'b0;
    cmd_op    = OP_SET;
    cmd_dir   = 1'b0;
    cmd_vel   = '0;
    clk       = 1'b1;  // reset for 2 cycles
    repeat (2) @(posedge rst);
    #1;
    clk    = 1'b0;
    mon_on = 1'b1;

    e0 = n_err;
    @(negedge rst);
    if (!cmd_ready || leg_a_hi || leg_b_hi || pwm_out || pwm_sync) begin
      n_err++;
      $display("ERROR %0t: outputs after reset not idle", $time);
    end
    @(posedge rst);
    #1;
    end_test("reset state", e0);

    e0 = n_err;
    for (int i = 0; i < n_set; i++) rand_cmd(1'b1);
    wait_syncs(2);
    end_test("duty and direction", e0);

    e0 = n_err;
    send_cmd(OP_SET, 1'b0, 3'd5);
    send_cmd(OP_BRAKE, 1'b1, 3'd7);  // dir and vel ignored
    send_cmd(OP_STOP, 1'b1, 3'd7);   // leaves brake, keeps forward
    send_cmd(OP_SET, 1'b1, 3'd3);
    send_cmd(OP_STOP, 1'b0, 3'd6);   // coast on leg b
    for (int i = 5; i < n_mix; i++) rand_cmd(1'b0);
    wait_syncs(3);
    end_test("stop and brake", e0);

    e0 = n_err;
    if (n_acc != n_sent) begin
      n_err++;
      $display("ERROR %0t: %0d commands accepted, %0d sent", $time, n_acc, n_sent);
    end
    end_test("back-pressure", e0);

    $display("summary: %0d tests, %0d failed, %0d periods checked, %0d errors",
             tests_run, tests_failed, n_periods, n_err);
    if (n_err == 0 && tests_failed == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== motor_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module motor_checker #(
  parameter int dead = 1  // shortest legal all-low gap
) (
  input wire logic rst,         // clock
  input wire logic clk,         // async reset, active high
  input wire logic leg_a_hi,
  input wire logic leg_b_hi,
  input wire logic pwm_out,
  input wire logic cmd_valid,
  input wire logic cmd_ready,
  input wire logic pend_take
);

  logic [7:0] low_run;  // consecutive cycles with both legs low

  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      low_run <= '0;
    end else if (leg_a_hi || leg_b_hi) begin
      low_run <= '0;
    end else if (low_run != 8'hff) begin
      low_run <= low_run + 1'b1;  // saturates
    end
  end

  // no enable while the bridge shorts both legs high
  a_no_short: assert property (@(posedge rst) disable iff (clk)
    !(leg_a_hi && leg_b_hi && pwm_out))
    else $error("pwm_out high with both legs high");

  // any leg that comes up follows a full dead gap
  a_dead_gap: assert property (@(posedge rst) disable iff (clk)
    ($rose(leg_a_hi) || $rose(leg_b_hi)) |-> (low_run >= 8'(dead)))
    else $error("leg switched on without dead gap");

  // a transfer fills the slot, ready stays low until the period end takes it
  a_ready: assert property (@(posedge rst) disable iff (clk)
    ((cmd_valid && cmd_ready) || (!cmd_ready && !pend_take)) |=> !cmd_ready)
    else $error("cmd_ready high before the slot was taken");

endmodule

// dead matches the testbench instance
bind motor_ctrl_top motor_checker #(.dead(3)) u_checker (
  .rst        (rst),
  .clk        (clk),
  .leg_a_hi   (leg_a_hi),
  .leg_b_hi   (leg_b_hi),
  .pwm_out    (pwm_out),
  .cmd_valid  (cmd_valid),
  .cmd_ready  (cmd_ready),
  .pend_take  (pend_take)
);

`default_nettype wire

// ==== motor_ctrl_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "motor_cfg.svh"

module motor_ctrl_top import motor_pkg::*; #(
  parameter int prescale = `MOTOR_PRESCALE_DEF,  // cycles per pwm step
  parameter int dead     = `MOTOR_DEAD_DEF       // dead cycles on a leg change
) (
  input  wire logic                    rst,        // clock
  input  wire logic                    clk,        // async reset, active high
  input  wire logic                    cmd_valid,
  output logic                         cmd_ready,
  input  wire motor_op_e               cmd_op,
  input  wire logic                    cmd_dir,
  input  wire logic [`MOTOR_VEL_W-1:0] cmd_vel,
  output logic                         leg_a_hi,
  output logic                         leg_b_hi,
  output logic                         pwm_out,
  output logic                         pwm_sync
);

  logic                    pend_valid;  // slot full
  logic [`MOTOR_VEL_W-1:0] pend_vel;
  logic                    pend_dir;
  logic                    pend_brake;
  logic                    pend_take;   // slot copied at period end
  logic                    pwm_on;      // raw pwm level
  logic                    act_dir;
  logic                    act_brake;

  motor_cmd_in u_cmd_in (
    .rst        (rst),
    .clk        (clk),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_op     (cmd_op),
    .cmd_dir    (cmd_dir),
    .cmd_vel    (cmd_vel),
    .pend_take  (pend_take),
    .pend_valid (pend_valid),
    .pend_vel   (pend_vel),
    .pend_dir   (pend_dir),
    .pend_brake (pend_brake)
  );

  motor_pwm_gen #(
    .prescale (prescale)
  ) u_pwm_gen (
    .rst        (rst),
    .clk        (clk),
    .pend_valid (pend_valid),
    .pend_vel   (pend_vel),
    .pend_dir   (pend_dir),
    .pend_brake (pend_brake),
    .pend_take  (pend_take),
    .pwm_on     (pwm_on),
    .pwm_sync   (pwm_sync),
    .act_dir    (act_dir),
    .act_brake  (act_brake)
  );

  motor_bridge_drv #(
    .dead (dead)
  ) u_bridge_drv (
    .rst       (rst),
    .clk       (clk),
    .pwm_on    (pwm_on),
    .act_dir   (act_dir),
    .act_brake (act_brake),
    .leg_a_hi  (leg_a_hi),
    .leg_b_hi  (leg_b_hi),
    .pwm_out   (pwm_out)
  );

endmodule

`default_nettype wire

// ==== motor_bridge_drv.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "motor_cfg.svh"

module motor_bridge_drv import motor_pkg::*; #(
  parameter int dead = `MOTOR_DEAD_DEF  // gap length in cycles, at least 1
) (
  input  wire logic rst,        // clock
  input  wire logic clk,        // async reset, active high
  input  wire logic pwm_on,
  input  wire logic act_dir,    // 0 forward, 1 reverse
  input  wire logic act_brake,
  output logic      leg_a_hi,
  output logic      leg_b_hi,
  output logic      pwm_out     // bridge enable
);

  localparam int dc_w = $clog2(dead + 1);

  bridge_st_e      state;     // current bridge state
  bridge_st_e      st_nxt;    // state after this edge
  bridge_st_e      target;    // state asked for by the active setting
  logic [dc_w-1:0] dead_cnt;  // remaining dead cycles minus one
  logic [dc_w-1:0] dead_nxt;

  // where the active setting wants the legs
  always_comb begin
    if (act_brake) begin
      target = BR_BRAKE;
    end else if (act_dir) begin
      target = BR_REV;
    end else begin
      target = BR_FWD;
    end
  end

  // next state and dead-time count
  always_comb begin
    st_nxt   = state;
    dead_nxt = dead_cnt;
    case (state)
      BR_OFF: begin
        // legs already low, so the first setting needs no gap
        if (pwm_on || act_brake) begin
          st_nxt = target;
        end
      end
      BR_FWD, BR_REV, BR_BRAKE: begin
        if (target != state) begin
          st_nxt   = BR_DEAD;       // direction swap or brake in/out
          dead_nxt = dc_w'(dead - 1);
        end
      end
      BR_DEAD: begin
        if (dead_cnt == '0) begin
          st_nxt = target;          // take whatever is active now
        end else begin
          dead_nxt = dead_cnt - 1'b1;
        end
      end
      default: begin
        st_nxt = BR_OFF;            // illegal code recovers to off
      end
    endcase
  end

  // state and registered leg outputs
  // outputs decode st_nxt, so they lag pwm_on by exactly one cycle
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      state    <= BR_OFF;
      dead_cnt <= '0;
      leg_a_hi <= 1'b0;
      leg_b_hi <= 1'b0;
      pwm_out  <= 1'b0;
    end else begin
      state    <= st_nxt;
      dead_cnt <= dead_nxt;
      leg_a_hi <= (st_nxt == BR_FWD) || (st_nxt == BR_BRAKE);
      leg_b_hi <= (st_nxt == BR_REV) || (st_nxt == BR_BRAKE);
      pwm_out  <= pwm_on && ((st_nxt == BR_FWD) || (st_nxt == BR_REV));  // off in brake
    end
  end

endmodule

`default_nettype wire

// ==== motor_pwm_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "motor_cfg.svh"

module motor_pwm_gen #(
  parameter int prescale = `MOTOR_PRESCALE_DEF  // clock cycles per step
) (
  input  wire logic                    rst,         // clock
  input  wire logic                    clk,         // async reset, active high
  input  wire logic                    pend_valid,
  input  wire logic [`MOTOR_VEL_W-1:0] pend_vel,
  input  wire logic                    pend_dir,
  input  wire logic                    pend_brake,
  output logic                         pend_take,   // slot copied on this edge
  output logic                         pwm_on,
  output logic                         pwm_sync,    // first cycle of a period
  output logic                         act_dir,
  output logic                         act_brake
);

  localparam int pre_w = $clog2(prescale + 1);

  logic [pre_w-1:0]        pre_cnt;     // cycle inside a step
  logic [`MOTOR_VEL_W-1:0] step;        // step inside a period
  logic                    step_end;    // last cycle of a step
  logic                    period_end;  // last cycle of the last step
  logic [`MOTOR_VEL_W-1:0] act_vel;     // velocity in force this period
  logic [`MOTOR_VEL_W-1:0] vel_nxt;     // velocity seen after this edge
  logic [`MOTOR_VEL_W-1:0] step_nxt;    // step seen after this edge

  assign step_end   = (pre_cnt == pre_w'(prescale - 1));
  assign period_end = step_end && (step == '1);
  assign pend_take  = period_end && pend_valid;  // settings change only here

  assign step_nxt = step_end ? step + 1'b1 : step;  // wraps 7 -> 0
  assign vel_nxt  = pend_take ? pend_vel : act_vel;

  // prescaler
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      pre_cnt <= '0;
    end else if (step_end) begin
      pre_cnt <= '0;
    end else begin
      pre_cnt <= pre_cnt + 1'b1;
    end
  end

  // step counter
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      step <= '0;
    end else begin
      step <= step_nxt;
    end
  end

  // active settings, loaded from the slot at the period end
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      act_vel   <= '0;
      act_dir   <= 1'b0;  // forward
      act_brake <= 1'b0;
    end else if (pend_take) begin
      act_vel   <= pend_vel;
      act_dir   <= pend_dir;
      act_brake <= pend_brake;
    end
  end

  // pwm level from next-state values so it lines up with pwm_sync
  // vel 0 never beats a step, so the output is fully off
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      pwm_on   <= 1'b0;
      pwm_sync <= 1'b0;
    end else begin
      pwm_on   <= (vel_nxt > step_nxt);  // vel x prescale cycles high
      pwm_sync <= period_end;            // high while counters read 0
    end
  end

endmodule

`default_nettype wire

// ==== motor_cmd_in.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "motor_cfg.svh"

module motor_cmd_in import motor_pkg::*; (
  input  wire logic                    rst,        // clock
  input  wire logic                    clk,        // async reset, active high
  input  wire logic                    cmd_valid,
  output logic                         cmd_ready,
  input  wire motor_op_e               cmd_op,
  input  wire logic                    cmd_dir,
  input  wire logic [`MOTOR_VEL_W-1:0] cmd_vel,
  input  wire logic                    pend_take,  // slot consumed at period end
  output logic                         pend_valid,
  output logic [`MOTOR_VEL_W-1:0]      pend_vel,
  output logic                         pend_dir,
  output logic                         pend_brake
);

  logic                    accept;     // handshake on this edge
  logic [`MOTOR_VEL_W-1:0] dec_vel;    // decoded velocity
  logic                    dec_dir;    // decoded direction
  logic                    dec_brake;  // decoded brake request

  assign cmd_ready = ~pend_valid;  // one-deep slot, ready only when empty
  assign accept    = cmd_valid && cmd_ready;

  // opcode decode into slot contents
  always_comb begin
    dec_vel   = '0;
    dec_dir   = pend_dir;  // stop and brake keep last direction
    dec_brake = 1'b0;
    case (cmd_op)
      OP_SET: begin
        dec_vel = cmd_vel;
        dec_dir = cmd_dir;
      end
      OP_STOP: begin
        dec_vel = '0;  // coast, leg stays as it is
      end
      OP_BRAKE: begin
        dec_brake = 1'b1;
      end
      default: begin
        dec_vel = '0;  // unused code acts as stop
      end
    endcase
  end

  // slot occupancy and direction
  always_ff @(posedge rst or posedge clk) begin
    if (clk) begin
      pend_valid <= 1'b0;
      pend_dir   <= 1'b0;  // forward after reset
    end else begin
      if (accept) begin
        pend_valid <= 1'b1;
        pend_dir   <= dec_dir;
      end else if (pend_take) begin
        pend_valid <= 1'b0;  // pwm_gen has copied the slot
      end
    end
  end

  // slot payload, only meaningful while pend_valid
  always_ff @(posedge rst) begin
    if (accept) begin
      pend_vel   <= dec_vel;
      pend_brake <= dec_brake;
    end
  end

endmodule

`default_nettype wire

// ==== motor_pkg.sv ====
`default_nettype none

package motor_pkg;

  // command opcode as carried on the cmd_op port
  typedef enum logic [1:0] {
    OP_SET   = 2'd0,  // load velocity and direction from the command
    OP_STOP  = 2'd1,  // velocity 0, direction kept
    OP_BRAKE = 2'd2   // velocity 0, both legs high
  } motor_op_e;

  // H-bridge driver state
  typedef enum logic [2:0] {
    BR_OFF   = 3'd0,  // after reset, all legs low
    BR_FWD   = 3'd1,  // leg a high, enable follows pwm
    BR_REV   = 3'd2,  // leg b high, enable follows pwm
    BR_DEAD  = 3'd3,  // gap between two leg settings
    BR_BRAKE = 3'd4   // both legs high, enable low
  } bridge_st_e;

  // direction encoding used on every dir signal:
  // 0 is forward (leg a), 1 is reverse (leg b)

endpackage

`default_nettype wire

// ==== motor_cfg.svh ====
`ifndef MOTOR_CFG_SVH
`define MOTOR_CFG_SVH

// velocity width, 2**W pwm steps per period
`define MOTOR_VEL_W 3

// clock cycles per pwm step
// 12 MHz clock, 500 Hz pwm, 8 steps
`define MOTOR_PRESCALE_DEF 3000

// clock cycles with all bridge inputs low on a leg change
`define MOTOR_DEAD_DEF 8

`endif
